/* files.f */
+incdir+source
source/gpio_pkg.sv
source/gpio_ahb_frontend.sv
source/gpio_bank.sv
source/gpio_read_mux.sv
source/gpio_subsystem.sv
testbench/gpio_subsystem_sva.sv
testbench/tb_gpio_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_gpio_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "sim_$TOP" \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
"./$BUILD_DIR/sim_$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation log has no result line"
    exit 1
fi

exit 0

/* testbench/tb_gpio_subsystem.sv */
// GPIO subsystem testbench

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module tb_gpio_subsystem
    import gpio_pkg::*;
();

    localparam int NB         = `GPIO_NUM_BANKS;
    localparam int RST_CYCLES = 8;
    localparam int N_ROUNDS   = 3;
    localparam int N_SUBWORD  = 16;
    localparam int N_PIN_SETS = 8;
    localparam int N_B2B      = 8;

    // Two cycles per read or write, one per pin check
    localparam int PLANNED_CYCLES = RST_CYCLES + 1
                                  + NB * 4 + 1
                                  + N_ROUNDS * NB * 2 * 5
                                  + N_SUBWORD * 5
                                  + N_PIN_SETS * (2 + NB * 4)
                                  + N_B2B * 11
                                  + 2;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    logic                             clk;
    logic                             RSTn;
    logic                             i_hsel;
    logic [31:0]                      i_haddr;
    logic [1:0]                       i_htrans;
    logic [2:0]                       i_hsize;
    logic                             i_hwrite;
    logic [31:0]                      i_hwdata;
    logic                             i_hready;
    logic [31:0]                      o_hrdata;
    logic [NB-1:0][`GPIO_BANK_W-1:0]  i_pin_in;
    logic [NB-1:0][`GPIO_BANK_W-1:0]  o_pin_out;
    logic [NB-1:0][`GPIO_BANK_W-1:0]  o_pin_oe;

    // Reference model
    logic [31:0] m_dout   [NB];
    logic [31:0] m_oe     [NB];
    logic [31:0] m_pin_in [NB];    // Held pin values

    logic [31:0] rng_state   = 32'd41952;
    int          data_errs   = 0;
    int          pin_errs    = 0;
    int          cycle_count = 0;

    always #4 clk = ~clk;

    gpio_subsystem u_gpio_subsystem
    (
        .clk       (clk),
        .RSTn      (RSTn),
        .i_hsel    (i_hsel),
        .i_haddr   (i_haddr),
        .i_htrans  (i_htrans),
        .i_hsize   (i_hsize),
        .i_hwrite  (i_hwrite),
        .i_hwdata  (i_hwdata),
        .i_hready  (i_hready),
        .o_hrdata  (o_hrdata),
        .i_pin_in  (i_pin_in),
        .o_pin_out (o_pin_out),
        .o_pin_oe  (o_pin_oe)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Lanes from transfer size and low address bits
    function automatic logic [31:0] merge_model(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [2:0]  size,
                                                input logic [1:0]  lo);
        logic [31:0] res;
        logic        hit;
        res = old_val;
        for (int i = 0; i < 4; i++)
        begin
            case (size)
                3'd0:    hit = (i == int'(lo));
                3'd1:    hit = ((i / 2) == int'(lo[1]));  // Lane pair
                default: hit = 1'b1;
            endcase
            if (hit)
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    function automatic void model_write(input int bank, input gpio_reg_e rsel,
                                        input logic [2:0] size, input logic [1:0] lo,
                                        input logic [31:0] data);
        case (rsel)
            REG_DOUT: m_dout[bank] = merge_model(m_dout[bank], data, size, lo);
            REG_OE:   m_oe[bank]   = merge_model(m_oe[bank], data, size, lo);
            default:  ;                                  // Read only
        endcase
    endfunction

    function automatic logic [31:0] expect_read(input int bank, input gpio_reg_e rsel);
        logic [31:0] view;
        case (rsel)
            REG_DOUT: return m_dout[bank];
            REG_OE:   return m_oe[bank];
            REG_DIN:  return m_pin_in[bank];
            default:
            begin
                // Each bit follows its output when driven
                for (int i = 0; i < 32; i++)
                    view[i] = m_oe[bank][i] ? m_dout[bank][i] : m_pin_in[bank][i];
                return view;
            end
        endcase
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            data_errs++;
        end
    endtask

    // --------------------------------------------------
    // Bus master
    // --------------------------------------------------

    task automatic drive_addr(input int bank, input gpio_reg_e rsel, input logic [2:0] size,
                              input logic [1:0] lo, input logic write);
        i_hsel   = 1'b1;
        i_htrans = 2'b10;                                // NONSEQ
        i_haddr  = '0;
        i_haddr[`GPIO_BANK_LSB +: 2] = 2'(bank);
        i_haddr[`GPIO_REG_LSB +: 2]  = rsel;
        i_haddr[1:0] = lo;
        i_hsize  = size;
        i_hwrite = write;
    endtask

    task automatic idle_bus();
        i_hsel   = 1'b0;
        i_htrans = 2'b00;
        i_hwrite = 1'b0;
    endtask

    task automatic bus_write(input int bank, input gpio_reg_e rsel, input logic [2:0] size,
                             input logic [1:0] lo, input logic [31:0] data);
        @(negedge clk);
        drive_addr(bank, rsel, size, lo, 1'b1);
        @(negedge clk);
        idle_bus();
        i_hwdata = data;                                 // Held until the next write
        model_write(bank, rsel, size, lo, data);
    endtask

    task automatic read_check(input int bank, input gpio_reg_e rsel);
        logic [31:0] got;
        @(negedge clk);
        drive_addr(bank, rsel, 3'd2, 2'b00, 1'b0);
        @(negedge clk);
        got = o_hrdata;                                  // Mid data phase
        idle_bus();
        check_word($sformatf("bank %0d %s", bank, rsel.name()), got, expect_read(bank, rsel));
    endtask

    // Write address phase overlapped by the read address phase
    task automatic write_then_read(input int bank, input gpio_reg_e rsel,
                                   input logic [31:0] data);
        logic [31:0] got;
        @(negedge clk);
        drive_addr(bank, rsel, 3'd2, 2'b00, 1'b1);
        @(negedge clk);
        i_hwdata = data;
        model_write(bank, rsel, 3'd2, 2'b00, data);
        drive_addr(bank, rsel, 3'd2, 2'b00, 1'b0);
        @(negedge clk);
        got = o_hrdata;
        idle_bus();
        check_word($sformatf("b2b bank %0d %s", bank, rsel.name()), got,
                   expect_read(bank, rsel));
    endtask

    task automatic check_pins();
        @(negedge clk);
        for (int b = 0; b < NB; b++)
        begin
            assert (o_pin_out[b] === m_dout[b] && o_pin_oe[b] === m_oe[b])
            else
            begin
                $display("** Error at %0t: bank %0d pins %08h oe %08h, expected %08h %08h",
                         $time, b, o_pin_out[b], o_pin_oe[b], m_dout[b], m_oe[b]);
                pin_errs++;
            end
        end
    endtask

    task automatic set_pins();
        @(negedge clk);
        for (int b = 0; b < NB; b++)
        begin
            m_pin_in[b] = next_rand();
            i_pin_in[b] = m_pin_in[b];
        end
        @(negedge clk);                                  // Let the synchronizer fill
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] r;
        int          bank;
        int          sva_fails;
        gpio_reg_e   rsel;
        logic [2:0]  size;
        logic [1:0]  lo;
        clk      = 1'b0;
        RSTn     = 1'b0;
        i_hready = 1'b1;
        i_hwdata = '0;
        i_haddr  = '0;
        i_hsize  = 3'd2;
        i_pin_in = '0;
        idle_bus();
        for (int b = 0; b < NB; b++)
        begin
            m_dout[b]   = '0;
            m_oe[b]     = '0;
            m_pin_in[b] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        RSTn = 1'b1;

        // Reset values
        for (int b = 0; b < NB; b++)
        begin
            read_check(b, REG_DOUT);
            read_check(b, REG_OE);
        end
        check_pins();

        // Full words on one bank while the others hold
        for (int n = 0; n < N_ROUNDS; n++)
            for (int b = 0; b < NB; b++)
                for (int k = 0; k < 2; k++)
                begin
                    rsel = (k == 1) ? REG_OE : REG_DOUT;
                    bus_write(b, rsel, 3'd2, 2'b00, next_rand());
                    check_pins();
                    read_check(b, rsel);
                end

        // Bytes and halfwords
        for (int n = 0; n < N_SUBWORD; n++)
        begin
            r    = next_rand();
            bank = int'(r[1:0]);
            rsel = r[2] ? REG_OE : REG_DOUT;
            size = (n % 2 == 1) ? 3'd1 : 3'd0;
            lo   = (size == 3'd1) ? {r[4], 1'b0} : r[5:4];
            bus_write(bank, rsel, size, lo, next_rand());
            check_pins();
            read_check(bank, rsel);
        end

        // Input path and pin view
        for (int n = 0; n < N_PIN_SETS; n++)
        begin
            set_pins();
            for (int b = 0; b < NB; b++)
            begin
                read_check(b, REG_DIN);
                read_check(b, REG_PINS);
            end
        end

        // Back to back transfers and ignored writes to read only registers
        for (int n = 0; n < N_B2B; n++)
        begin
            r    = next_rand();
            bank = int'(r[1:0]);
            write_then_read(bank, r[2] ? REG_OE : REG_DOUT, next_rand());
            write_then_read(bank, r[3] ? REG_PINS : REG_DIN, next_rand());
            read_check(bank, REG_DOUT);
            read_check(bank, REG_OE);
            check_pins();
        end

        repeat (2) @(negedge clk);
        sva_fails = u_gpio_subsystem.u_sva.fail_count;
        $display("Errors: data %0d, pins %0d, assertions %0d", data_errs, pin_errs, sva_fails);
        if (data_errs == 0 && pin_errs == 0 && sva_fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/gpio_subsystem_sva.sv */
// GPIO subsystem assertions

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_subsystem_sva
    import gpio_pkg::*;
(
    input wire logic                                          clk,
    input wire logic                                          RSTn,
    input wire logic                                          i_hsel,
    input wire logic [31:0]                                   i_haddr,
    input wire logic [1:0]                                    i_htrans,
    input wire logic                                          i_hwrite,
    input wire logic                                          i_hready,
    input wire logic [31:0]                                   i_hrdata,
    input wire logic [`GPIO_NUM_BANKS-1:0][`GPIO_BANK_W-1:0]  i_pin_out,
    input wire logic [`GPIO_NUM_BANKS-1:0][`GPIO_BANK_W-1:0]  i_pin_oe
);

    int unsigned                fail_count = 0;
    logic                       accept;
    logic                       acc_rd;
    logic [`GPIO_NUM_BANKS-1:0] acc_oe_wr;     // OE write accepted, per bank

    assign accept = i_hsel & i_hready & i_htrans[1];
    assign acc_rd = accept & ~i_hwrite;

    // Pins come out of reset undriven
    a_reset_pins: assert property (@(posedge clk)
        $rose(RSTn) |-> (i_pin_oe == '0 && i_pin_out == '0))
    else
    begin
        fail_count++;
        $error("pin outputs not zero after reset");
    end

    // HRDATA idles at zero
    a_idle_rdata: assert property (@(posedge clk) disable iff (!RSTn)
        !$past(acc_rd) |-> (i_hrdata == '0))
    else
    begin
        fail_count++;
        $error("nonzero read data outside a read data phase");
    end

    genvar g;
    generate
        for (g = 0; g < `GPIO_NUM_BANKS; g++)
        begin : g_oe
            assign acc_oe_wr[g] = accept & i_hwrite
                                & (i_haddr[`GPIO_BANK_LSB +: `GPIO_BANK_IDX_W] == 2'(g))
                                & (i_haddr[`GPIO_REG_LSB +: `GPIO_REG_W] == REG_OE);

            // Address phase, data phase, then the change shows
            a_oe_stable: assert property (@(posedge clk) disable iff (!RSTn)
                $changed(i_pin_oe[g]) |-> $past(acc_oe_wr[g], 2))
            else
            begin
                fail_count++;
                $error("bank %0d output enable changed without an OE write", g);
            end
        end
    endgenerate

endmodule

bind gpio_subsystem gpio_subsystem_sva u_sva
(
    .clk       (clk),
    .RSTn      (RSTn),
    .i_hsel    (i_hsel),
    .i_haddr   (i_haddr),
    .i_htrans  (i_htrans),
    .i_hwrite  (i_hwrite),
    .i_hready  (i_hready),
    .i_hrdata  (o_hrdata),
    .i_pin_out (o_pin_out),
    .i_pin_oe  (o_pin_oe)
);

`default_nettype wire

/* source/gpio_subsystem.sv */
// GPIO subsystem top

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_subsystem
    import gpio_pkg::*;
(
    input  wire logic                                          clk,
    input  wire logic                                          RSTn,

    // AHB-Lite slave
    input  wire logic                                          i_hsel,
    input  wire logic [31:0]                                   i_haddr,
    input  wire logic [1:0]                                    i_htrans,
    input  wire logic [2:0]                                    i_hsize,
    input  wire logic                                          i_hwrite,
    input  wire logic [31:0]                                   i_hwdata,
    input  wire logic                                          i_hready,
    output      logic [31:0]                                   o_hrdata,

    // Pins, one row per bank
    input  wire logic [`GPIO_NUM_BANKS-1:0][`GPIO_BANK_W-1:0]  i_pin_in,
    output      logic [`GPIO_NUM_BANKS-1:0][`GPIO_BANK_W-1:0]  o_pin_out,
    output      logic [`GPIO_NUM_BANKS-1:0][`GPIO_BANK_W-1:0]  o_pin_oe
);

    gpio_wr_t         [`GPIO_NUM_BANKS-1:0] bank_wr;
    gpio_rd_sel_t                           rd_sel;
    gpio_bank_state_t [`GPIO_NUM_BANKS-1:0] bank_state;

    // --------------------------------------------------
    // Bus front end
    // --------------------------------------------------

    gpio_ahb_frontend u_frontend
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_hsel     (i_hsel),
        .i_haddr    (i_haddr),
        .i_htrans   (i_htrans),
        .i_hsize    (i_hsize),
        .i_hwrite   (i_hwrite),
        .i_hwdata   (i_hwdata),
        .i_hready   (i_hready),
        .o_bank_wr  (bank_wr),
        .o_rd_sel   (rd_sel)
    );

    // --------------------------------------------------
    // Banks
    // --------------------------------------------------

    genvar g;
    generate
        for (g = 0; g < `GPIO_NUM_BANKS; g++)
        begin : g_bank
            gpio_bank u_bank
            (
                .clk      (clk),
                .RSTn     (RSTn),
                .i_wr     (bank_wr[g]),
                .i_pin_in (i_pin_in[g]),
                .o_state  (bank_state[g])
            );

            assign o_pin_out[g] = bank_state[g].dout;
            assign o_pin_oe[g]  = bank_state[g].oe;     // High means driven
        end
    endgenerate

    // Read path is purely combinational
    gpio_read_mux u_read_mux
    (
        .i_rd_sel   (rd_sel),
        .i_banks    (bank_state),
        .o_hrdata   (o_hrdata)
    );

endmodule

`default_nettype wire

/* source/gpio_read_mux.sv */
// GPIO read data mux

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_read_mux
    import gpio_pkg::*;
(
    input  gpio_rd_sel_t                           i_rd_sel,
    input  gpio_bank_state_t [`GPIO_NUM_BANKS-1:0] i_banks,
    output logic             [31:0]                o_hrdata
);

    gpio_bank_state_t        sel_bank;
    logic [`GPIO_BANK_W-1:0] pin_view;

    assign sel_bank = i_banks[i_rd_sel.bank];

    // Driven bits show the output, the rest show the input
    assign pin_view = (sel_bank.dout & sel_bank.oe)
                    | (sel_bank.din_sync & ~sel_bank.oe);

    // --------------------------------------------------
    // HRDATA select
    // --------------------------------------------------

    always_comb
    begin
        o_hrdata = '0;                     // Idle bus reads as zero
        if (i_rd_sel.valid)
        begin
            case (i_rd_sel.reg_sel)
                REG_DOUT: o_hrdata = sel_bank.dout;
                REG_OE:   o_hrdata = sel_bank.oe;
                REG_DIN:  o_hrdata = sel_bank.din_sync;
                REG_PINS: o_hrdata = pin_view;
                default:  o_hrdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/gpio_bank.sv */
// GPIO bank registers

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_bank
    import gpio_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    RSTn,
    input  gpio_wr_t                     i_wr,
    input  wire logic [`GPIO_BANK_W-1:0] i_pin_in,
    output gpio_bank_state_t             o_state
);

    logic [`GPIO_BANK_W-1:0] dout_q;
    logic [`GPIO_BANK_W-1:0] oe_q;
    logic [`GPIO_BANK_W-1:0] sync_meta;    // First stage, may go metastable
    logic [`GPIO_BANK_W-1:0] sync_q;

    // Replace only the enabled byte lanes
    function automatic logic [`GPIO_BANK_W-1:0] merge_lanes(
        input logic [`GPIO_BANK_W-1:0]     old_val,
        input logic [`GPIO_BANK_W-1:0]     new_val,
        input logic [`GPIO_BANK_BYTES-1:0] be
    );
        logic [`GPIO_BANK_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `GPIO_BANK_BYTES; i++)
        begin
            if (be[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            dout_q <= '0;
            oe_q   <= '0;                  // All pins start as inputs
        end
        else if (i_wr.valid)
        begin
            case (i_wr.reg_sel)
                REG_DOUT: dout_q <= merge_lanes(dout_q, i_wr.wdata, i_wr.byte_en);
                REG_OE:   oe_q   <= merge_lanes(oe_q, i_wr.wdata, i_wr.byte_en);
                default:  ;                // DIN and PINS are read only
            endcase
        end
    end

    // --------------------------------------------------
    // Input synchronizer
    // --------------------------------------------------

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            sync_meta <= '0;
            sync_q    <= '0;
        end
        else
        begin
            sync_meta <= i_pin_in;
            sync_q    <= sync_meta;
        end
    end

    assign o_state.dout     = dout_q;
    assign o_state.oe       = oe_q;
    assign o_state.din_sync = sync_q;

endmodule

`default_nettype wire

/* source/gpio_ahb_frontend.sv */
// GPIO AHB-Lite front end

`timescale 1ns/1ps
`default_nettype none

`include "gpio_consts.svh"

module gpio_ahb_frontend
    import gpio_pkg::*;
(
    input  wire logic                             clk,
    input  wire logic                             RSTn,
    input  wire logic                             i_hsel,
    input  wire logic [31:0]                      i_haddr,
    input  wire logic [1:0]                       i_htrans,
    input  wire logic [2:0]                       i_hsize,
    input  wire logic                             i_hwrite,
    input  wire logic [31:0]                      i_hwdata,
    input  wire logic                             i_hready,
    output gpio_wr_t     [`GPIO_NUM_BANKS-1:0]    o_bank_wr,
    output gpio_rd_sel_t                          o_rd_sel
);

    // --------------------------------------------------
    // Address phase capture
    // --------------------------------------------------

    logic                        accept;
    logic                        ap_valid;     // Data phase in progress
    logic                        ap_write;
    logic [`GPIO_BANK_IDX_W-1:0] ap_bank;
    gpio_reg_e                   ap_reg;
    logic [`GPIO_BANK_BYTES-1:0] ap_byte_en;
    logic                        wr_active;

    // Lanes touched by a transfer of the given size
    function automatic logic [`GPIO_BANK_BYTES-1:0] lanes_for(
        input logic [2:0] size,
        input logic [1:0] addr_lo
    );
        logic [`GPIO_BANK_BYTES-1:0] be;
        case (size)
            3'd0:    be = 4'b0001 << addr_lo;
            3'd1:    be = addr_lo[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;          // Word
        endcase
        return be;
    endfunction

    // Only NONSEQ and SEQ start a transfer
    assign accept = i_hsel & i_hready & i_htrans[1];

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            ap_valid <= 1'b0;
        end
        else if (i_hready)
        begin
            ap_valid <= accept;
        end
    end

    // Transfer attributes taken on acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ap_write   <= i_hwrite;
            ap_bank    <= i_haddr[`GPIO_BANK_LSB +: `GPIO_BANK_IDX_W];
            ap_reg     <= gpio_reg_e'(i_haddr[`GPIO_REG_LSB +: `GPIO_REG_W]);
            ap_byte_en <= lanes_for(i_hsize, i_haddr[1:0]);
        end
    end

    // --------------------------------------------------
    // Data phase commands
    // --------------------------------------------------

    assign wr_active = ap_valid & ap_write & i_hready;   // Last cycle of the write

    genvar g;
    generate
        for (g = 0; g < `GPIO_NUM_BANKS; g++)
        begin : g_wr
            assign o_bank_wr[g].valid   = wr_active && (ap_bank == 2'(g));
            assign o_bank_wr[g].reg_sel = ap_reg;
            assign o_bank_wr[g].byte_en = ap_byte_en;
            assign o_bank_wr[g].wdata   = i_hwdata;
        end
    endgenerate

    // Held for the whole read data phase
    assign o_rd_sel.valid   = ap_valid & ~ap_write;
    assign o_rd_sel.bank    = ap_bank;
    assign o_rd_sel.reg_sel = ap_reg;

endmodule

`default_nettype wire

/* source/gpio_pkg.sv */
// GPIO shared types

`default_nettype none

`include "gpio_consts.svh"

package gpio_pkg;

    // --------------------------------------------------
    // Register select
    // --------------------------------------------------

    typedef enum logic [`GPIO_REG_W-1:0] {
        REG_DOUT = 2'd0,    // Output data
        REG_OE   = 2'd1,    // Output enable
        REG_DIN  = 2'd2,    // Synchronized inputs, read only
        REG_PINS = 2'd3     // Pin view, read only
    } gpio_reg_e;

    // --------------------------------------------------
    // Bus side commands
    // --------------------------------------------------

    // Write command for one bank, valid only in the data phase
    typedef struct packed {
        logic                        valid;
        gpio_reg_e                   reg_sel;
        logic [`GPIO_BANK_BYTES-1:0] byte_en;   // One bit per lane
        logic [`GPIO_BANK_W-1:0]     wdata;
    } gpio_wr_t;

    // Read selection for the current data phase
    typedef struct packed {
        logic                        valid;
        logic [`GPIO_BANK_IDX_W-1:0] bank;
        gpio_reg_e                   reg_sel;
    } gpio_rd_sel_t;

    // Readable state of one bank
    typedef struct packed {
        logic [`GPIO_BANK_W-1:0] dout;      // Also drives the pins
        logic [`GPIO_BANK_W-1:0] oe;
        logic [`GPIO_BANK_W-1:0] din_sync;  // After two flops
    } gpio_bank_state_t;

endpackage

`default_nettype wire

/* source/gpio_consts.svh */
// GPIO block constants

`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// --------------------------------------------------
// Bank geometry
// --------------------------------------------------

`define GPIO_NUM_BANKS      4                   // Banks behind the slave
`define GPIO_BANK_W         32                  // Pins per bank
`define GPIO_BANK_BYTES     (`GPIO_BANK_W / 8)  // Byte lanes per register
`define GPIO_BANK_IDX_W     2                   // Bits to pick a bank

// --------------------------------------------------
// Address map
// --------------------------------------------------

// Word aligned registers, four per bank
`define GPIO_REG_LSB        2
`define GPIO_REG_W          2

// Bank field sits right above the register field
`define GPIO_BANK_LSB       4

`endif
